// ==== dv/arith_unit_assertions.sv ====
`timescale 1ns/1ps

module arith_unit_assertions (
    input logic                  bit_clk,
    input logic                  rst_n,
    input logic                  done,
    input logic                  busy,
    input logic                  active,
    input arith_pkg::bit_phase_s phase
);

    int unsigned fail_cnt = 0;

    // ************************************************
    // control and timing properties
    // ************************************************

    done_single: assert property (@(posedge bit_clk) disable iff (!rst_n)
        done |=> !done)
        else begin
            fail_cnt++;
            $error("done stayed high for two cycles");
        end

    active_busy: assert property (@(posedge bit_clk) disable iff (!rst_n)
        active |-> busy)
        else begin
            fail_cnt++;
            $error("active high while busy low");
        end

    phase_apart: assert property (@(posedge bit_clk) disable iff (!rst_n)
        !(phase.first_bit && phase.last_bit))
        else begin
            fail_cnt++;
            $error("first and last bit marked in the same cycle");
        end

    // done only right after an active last bit
    done_after_word: assert property (@(posedge bit_clk) disable iff (!rst_n)
        done |-> $past(active && phase.last_bit))
        else begin
            fail_cnt++;
            $error("done without an active last bit before it");
        end

endmodule

bind arith_unit arith_unit_assertions arith_unit_assertions_i (
    .bit_clk (bit_clk),
    .rst_n   (rst_n),
    .done    (done),
    .busy    (busy),
    .active  (active),
    .phase   (phase)
);

// ==== dv/arith_unit_tb.sv ====
`timescale 1ns/1ps

module arith_unit_tb;

    localparam int word_bits  = arith_pkg::word_bits_default;
    localparam int num_cmds   = 80;
    localparam int wait_limit = 3 * word_bits;

    logic                 bit_clk = 1'b0;
    logic                 rst_n;
    logic                 cmd_valid;
    arith_pkg::cmd_s      cmd;
    logic                 mem_bit;
    logic                 busy;
    logic                 done;
    logic [word_bits-1:0] acc_word;
    logic                 ovf;

    logic [31:0]          lfsr_state = 32'h1901773d;
    logic [word_bits-1:0] operand_q;
    logic [word_bits-1:0] model_acc;
    logic                 model_ovf;
    int                   cycle_cnt;
    int                   error_cnt;
    int                   done_cnt;
    int                   accepted_cnt;
    logic                 timed_out;

    arith_unit #(.WORD_BITS(word_bits)) arith_unit_i (
        .bit_clk   (bit_clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .mem_bit   (mem_bit),
        .busy      (busy),
        .done      (done),
        .acc_word  (acc_word),
        .ovf       (ovf)
    );

    always #2 bit_clk = ~bit_clk;

    // ************************************************
    // random bits and checks
    // ************************************************

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            error_cnt++;
            $display("** Error %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    // one clock, outputs sampled before the new inputs go out
    task automatic tick();
        @(posedge bit_clk);
        if (rst_n) begin
            cycle_cnt++;
        end
        #1;
        if (done) begin
            done_cnt++;
        end
        cmd_valid = 1'b0;
        // operand bit i sits on the line during bit time i
        mem_bit = operand_q[cycle_cnt % word_bits];
    endtask

    // ************************************************
    // reference model
    // ************************************************

    task automatic apply_model(input arith_pkg::op_e op, input logic clr,
                               input logic [word_bits-1:0] m);
        logic [word_bits-1:0] r;
        logic                 a_s;
        a_s = model_acc[word_bits-1];
        if (clr) begin
            model_ovf = 1'b0;
        end
        case (op)
            arith_pkg::op_clear_add: model_acc = m;
            arith_pkg::op_add: begin
                r = model_acc + m;
                if (a_s == m[word_bits-1] && r[word_bits-1] != a_s) begin
                    model_ovf = 1'b1;
                end
                model_acc = r;
            end
            arith_pkg::op_sub: begin
                r = model_acc - m;
                // negated operand carries the opposite sign
                if (a_s != m[word_bits-1] && r[word_bits-1] != a_s) begin
                    model_ovf = 1'b1;
                end
                model_acc = r;
            end
            default: model_acc = model_acc & m;
        endcase
    endtask

    task automatic run_command();
        logic [31:0] op_bits;
        logic [31:0] clr_bits;
        logic [31:0] m_bits;
        logic [31:0] gap;
        logic [31:0] extra;
        logic [31:0] extra_at;
        logic [31:0] extra_cmd;
        int          waited;
        int          strobe_cycle;
        draw_bits(2, op_bits);
        draw_bits(2, clr_bits);
        draw_bits(word_bits, m_bits);
        draw_bits(2, gap);
        draw_bits(1, extra);
        draw_bits(3, extra_at);
        draw_bits(3, extra_cmd);

        waited = 0;
        while (busy && waited < wait_limit) begin
            tick();
            waited++;
        end
        if (busy) begin
            $display("timeout: busy did not fall before a new command");
            timed_out = 1'b1;
            return;
        end
        repeat (gap[1:0]) tick();

        cmd_valid     = 1'b1;
        cmd.op        = arith_pkg::op_e'(op_bits[1:0]);
        cmd.clear_ovf = &clr_bits[1:0];
        operand_q     = m_bits[word_bits-1:0];
        strobe_cycle  = cycle_cnt;
        accepted_cnt++;
        apply_model(cmd.op, cmd.clear_ovf, operand_q);
        tick();

        waited = 0;
        while (!done && waited < wait_limit) begin
            check_value("busy", 1, busy);
            // a second strobe while busy must be dropped
            if (extra[0] && waited == int'(extra_at[2:0]) + 1) begin
                cmd_valid     = 1'b1;
                cmd.op        = arith_pkg::op_e'(extra_cmd[1:0]);
                cmd.clear_ovf = extra_cmd[2];
            end
            tick();
            waited++;
        end
        if (!done) begin
            $display("timeout: no done pulse after an accepted command");
            timed_out = 1'b1;
            return;
        end
        check_value("done latency", 2 * word_bits - strobe_cycle % word_bits,
                    cycle_cnt - strobe_cycle);
        check_value("busy", 0, busy);
        check_value("acc_word", model_acc, acc_word);
        check_value("ovf", model_ovf, ovf);
        tick();
        check_value("done", 0, done);
    endtask

    // ************************************************
    // main sequence
    // ************************************************

    initial begin
        int unsigned assert_fails;
        rst_n        = 1'b0;
        cmd_valid    = 1'b0;
        cmd          = '0;
        mem_bit      = 1'b0;
        operand_q    = '0;
        model_acc    = '0;
        model_ovf    = 1'b0;
        cycle_cnt    = 0;
        error_cnt    = 0;
        done_cnt     = 0;
        accepted_cnt = 0;
        timed_out    = 1'b0;

        repeat (2) tick();
        rst_n = 1'b1;
        tick();
        check_value("acc_word", 0, acc_word);
        check_value("ovf", 0, ovf);
        check_value("busy", 0, busy);
        check_value("done", 0, done);

        for (int i = 0; i < num_cmds && !timed_out; i++) begin
            run_command();
        end
        if (!timed_out) begin
            check_value("done pulses", accepted_cnt, done_cnt);
        end

        assert_fails = arith_unit_i.arith_unit_assertions_i.fail_cnt;
        $display("errors: %0d failed checks, %0d failed assertions, %0d timeouts",
                 error_cnt, assert_fails, timed_out);
        if (error_cnt == 0 && assert_fails == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
verilog/arith_pkg.sv
verilog/word_timing.sv
verilog/command_decode.sv
verilog/serial_alu.sv
verilog/accumulator_line.sv
verilog/arith_unit.sv
dv/arith_unit_assertions.sv
dv/arith_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the arithmetic unit testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module arith_unit_tb -f project.f \
    --Mdir "$OBJ" -o arith_unit_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$OBJ/arith_unit_sim" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$LOG"; then
    exit 1
fi
exit 0

// ==== verilog/accumulator_line.sv ====
`timescale 1ns/1ps

module accumulator_line #(
    parameter int WORD_BITS = arith_pkg::word_bits_default
) (
    input  logic                  bit_clk,
    input  logic                  rst_n,
    input  arith_pkg::bit_phase_s phase,
    input  logic                  active,
    input  logic                  result_bit,
    input  logic                  ovf_event,
    input  logic                  clear_ovf,
    output logic                  acc_bit,
    output logic [WORD_BITS-1:0]  acc_word,
    output logic                  ovf
);

    logic [WORD_BITS-1:0] line_q;
    logic [WORD_BITS-1:0] line_next;
    logic [WORD_BITS-1:0] lamp_q;
    logic                 ovf_q;

    // ************************************************
    // recirculating line
    // ************************************************

    // lsb leaves at the bottom, the new bit enters at the top
    assign line_next = {result_bit, line_q[WORD_BITS-1:1]};

    always_ff @(posedge bit_clk) begin
        if (!rst_n) begin
            line_q <= '0;
        end else if (active) begin
            line_q <= line_next;
        end
    end

    // lamps follow whole words only, steady while the line shifts
    always_ff @(posedge bit_clk) begin
        if (!rst_n) begin
            lamp_q <= '0;
        end else if (active && phase.last_bit) begin
            lamp_q <= line_next;
        end
    end

    // sticky overflow
    always_ff @(posedge bit_clk) begin
        if (!rst_n) begin
            ovf_q <= 1'b0;
        end else if (ovf_event) begin
            ovf_q <= 1'b1;
        end else if (clear_ovf) begin
            ovf_q <= 1'b0;
        end
    end

    assign acc_bit  = line_q[0];
    assign acc_word = lamp_q;
    assign ovf      = ovf_q;

endmodule

// ==== verilog/arith_pkg.sv ====
package arith_pkg;

    // ************************************************
    // word size
    // ************************************************

    // default word length, the top level passes it down as WORD_BITS
    localparam int word_bits_default = 24;

    // ************************************************
    // commands
    // ************************************************

    typedef enum logic [1:0] {
        op_clear_add = 2'b00,
        op_add       = 2'b01,
        op_sub       = 2'b10,
        op_and       = 2'b11
    } op_e;

    typedef struct packed {
        op_e  op;
        logic clear_ovf;
    } cmd_s;

    // ************************************************
    // per word control and bit timing
    // ************************************************

    typedef struct packed {
        logic invert_mem;
        logic carry_in;
        logic logic_and;
        logic use_acc;
        logic check_ovf;
    } exec_ctrl_s;

    typedef struct packed {
        logic first_bit;
        logic last_bit;
    } bit_phase_s;

endpackage

// ==== verilog/arith_unit.sv ====
`timescale 1ns/1ps

module arith_unit #(
    parameter int WORD_BITS = arith_pkg::word_bits_default
) (
    input  logic                 bit_clk,
    input  logic                 rst_n,
    input  logic                 cmd_valid,
    input  arith_pkg::cmd_s      cmd,
    input  logic                 mem_bit,
    output logic                 busy,
    output logic                 done,
    output logic [WORD_BITS-1:0] acc_word,
    output logic                 ovf
);

    arith_pkg::bit_phase_s phase;
    arith_pkg::exec_ctrl_s ctrl;
    logic                  active;
    logic                  clear_ovf;
    logic                  acc_bit;
    logic                  result_bit;
    logic                  ovf_event;

    // ************************************************
    // timing and control
    // ************************************************

    word_timing #(.WORD_BITS(WORD_BITS)) word_timing_i (
        .bit_clk (bit_clk),
        .rst_n   (rst_n),
        .phase   (phase)
    );

    command_decode command_decode_i (
        .bit_clk   (bit_clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .phase     (phase),
        .ctrl      (ctrl),
        .active    (active),
        .busy      (busy),
        .done      (done),
        .clear_ovf (clear_ovf)
    );

    // ************************************************
    // serial datapath
    // ************************************************

    serial_alu #(.WORD_BITS(WORD_BITS)) serial_alu_i (
        .bit_clk    (bit_clk),
        .rst_n      (rst_n),
        .phase      (phase),
        .ctrl       (ctrl),
        .active     (active),
        .acc_bit    (acc_bit),
        .mem_bit    (mem_bit),
        .result_bit (result_bit),
        .ovf_event  (ovf_event)
    );

    accumulator_line #(.WORD_BITS(WORD_BITS)) accumulator_line_i (
        .bit_clk    (bit_clk),
        .rst_n      (rst_n),
        .phase      (phase),
        .active     (active),
        .result_bit (result_bit),
        .ovf_event  (ovf_event),
        .clear_ovf  (clear_ovf),
        .acc_bit    (acc_bit),
        .acc_word   (acc_word),
        .ovf        (ovf)
    );

endmodule

// ==== verilog/command_decode.sv ====
`timescale 1ns/1ps

module command_decode (
    input  logic                  bit_clk,
    input  logic                  rst_n,
    input  logic                  cmd_valid,
    input  arith_pkg::cmd_s       cmd,
    input  arith_pkg::bit_phase_s phase,
    output arith_pkg::exec_ctrl_s ctrl,
    output logic                  active,
    output logic                  busy,
    output logic                  done,
    output logic                  clear_ovf
);

    // per word control from the operation code
    function automatic arith_pkg::exec_ctrl_s decode_op(input arith_pkg::op_e op);
        arith_pkg::exec_ctrl_s c;
        c = '0;
        case (op)
            arith_pkg::op_add: begin
                c.use_acc   = 1'b1;
                c.check_ovf = 1'b1;
            end
            arith_pkg::op_sub: begin
                c.invert_mem = 1'b1;
                c.carry_in   = 1'b1;
                c.use_acc    = 1'b1;
                c.check_ovf  = 1'b1;
            end
            arith_pkg::op_and: begin
                c.logic_and = 1'b1;
                c.use_acc   = 1'b1;
            end
            // clear-and-add drops the accumulator bit
            default: c = '0;
        endcase
        return c;
    endfunction

    logic           accept;
    logic           pending_q;
    logic           active_q;
    logic           done_q;
    arith_pkg::op_e op_q;

    assign accept = cmd_valid && !busy;

    always_ff @(posedge bit_clk) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
            active_q  <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= active_q && phase.last_bit;
            if (accept) begin
                pending_q <= 1'b1;
            end else if (pending_q && phase.first_bit) begin
                pending_q <= 1'b0;
                active_q  <= 1'b1;
            end else if (active_q && phase.last_bit) begin
                active_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge bit_clk) begin
        if (accept) begin
            op_q <= cmd.op;
        end
    end

    // the pending word becomes active right at its first bit
    assign active    = active_q || (pending_q && phase.first_bit);
    assign busy      = pending_q || active_q;
    assign done      = done_q;
    assign clear_ovf = accept && cmd.clear_ovf;
    assign ctrl      = decode_op(op_q);

endmodule

// ==== verilog/serial_alu.sv ====
`timescale 1ns/1ps

module serial_alu #(
    parameter int WORD_BITS = arith_pkg::word_bits_default
) (
    input  logic                  bit_clk,
    input  logic                  rst_n,
    input  arith_pkg::bit_phase_s phase,
    input  arith_pkg::exec_ctrl_s ctrl,
    input  logic                  active,
    input  logic                  acc_bit,
    input  logic                  mem_bit,
    output logic                  result_bit,
    output logic                  ovf_event
);

    logic a_bit;
    logic m_bit;
    logic carry_q;
    logic carry_in_bit;
    logic carry_out_bit;
    logic sum_bit;

    // first and last bit must fall in different cycles
    if (WORD_BITS < 4) begin : g_word_check
        $error("serial_alu: WORD_BITS must be 4 or more");
    end

    // ************************************************
    // operand conditioning
    // ************************************************

    // clear-and-add forces the accumulator bit to zero
    assign a_bit = acc_bit & ctrl.use_acc;
    // ones complement for subtract, the +1 comes in as carry
    assign m_bit = mem_bit ^ ctrl.invert_mem;

    // ************************************************
    // one bit adder
    // ************************************************

    assign carry_in_bit  = phase.first_bit ? ctrl.carry_in : carry_q;
    assign sum_bit       = a_bit ^ m_bit ^ carry_in_bit;
    assign carry_out_bit = (a_bit & m_bit) | (carry_in_bit & (a_bit ^ m_bit));

    assign result_bit = ctrl.logic_and ? (a_bit & m_bit) : sum_bit;

    // carry held between bit times
    always_ff @(posedge bit_clk) begin
        if (!rst_n) begin
            carry_q <= 1'b0;
        end else if (active) begin
            carry_q <= carry_out_bit;
        end
    end

    // signed overflow: carry into the sign bit differs from carry out
    assign ovf_event = active && phase.last_bit && ctrl.check_ovf &&
                       (carry_in_bit ^ carry_out_bit);

endmodule

// ==== verilog/word_timing.sv ====
`timescale 1ns/1ps

module word_timing #(
    parameter int WORD_BITS = arith_pkg::word_bits_default
) (
    input  logic                  bit_clk,
    input  logic                  rst_n,
    output arith_pkg::bit_phase_s phase
);

    localparam int cnt_w = $clog2(WORD_BITS);
    localparam logic [cnt_w-1:0] last_count = cnt_w'(WORD_BITS - 1);

    logic [cnt_w-1:0] bit_cnt;

    // ************************************************
    // bit time counter
    // ************************************************

    // free running from reset, so bit 0 is the first cycle after release
    always_ff @(posedge bit_clk) begin
        if (!rst_n) begin
            bit_cnt <= '0;
        end else if (bit_cnt == last_count) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // word boundary marks
    assign phase.first_bit = (bit_cnt == '0);
    assign phase.last_bit  = (bit_cnt == last_count);

endmodule
